/* fpm_wb_top.f */
+incdir+testbench
verilog/fpm_pkg.sv
verilog/sync_fifo.sv
verilog/wb_regs.sv
verilog/booth_pp_gen.sv
verilog/fp_round_pack.sv
verilog/fp_mul_pipe.sv
verilog/fpm_wb_top.sv
testbench/fpm_wb_chk.sv
testbench/tb_fpm.sv

/* run_sim.sh */
#!/bin/sh
# build and run tb_fpm with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_fpm -f fpm_wb_top.f -o tb_fpm
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_fpm
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

/* testbench/tb_fpm_vectors.svh */
`ifndef TB_FPM_VECTORS_SVH
`define TB_FPM_VECTORS_SVH

// columns: x, y, mode, expected z, expected ovrf, expected udrf
// first N_SINGLE run one at a time, the rest are queued with one mode
localparam int N_SINGLE = 19;
localparam int N_QUEUE  = 6;
localparam int N_VEC    = N_SINGLE + N_QUEUE;

localparam logic [100:0] VECS [N_VEC] = '{
  {32'h3FC00000, 32'h40000000, 3'd0, 32'h40400000, 1'b0, 1'b0}, // 1.5 * 2
  {32'hBFC00000, 32'h40000000, 3'd0, 32'hC0400000, 1'b0, 1'b0},
  {32'h3FC00000, 32'h3FC00000, 3'd0, 32'h40100000, 1'b0, 1'b0}, // product >= 2
  {32'h3F800001, 32'h3F800001, 3'd0, 32'h3F800002, 1'b0, 1'b0},
  {32'h3F800001, 32'h3F800001, 3'd1, 32'h3F800002, 1'b0, 1'b0},
  {32'h3F800001, 32'h3F800001, 3'd2, 32'h3F800002, 1'b0, 1'b0},
  {32'h3F800001, 32'h3F800001, 3'd3, 32'h3F800003, 1'b0, 1'b0},
  {32'hBF800001, 32'h3F800001, 3'd2, 32'hBF800003, 1'b0, 1'b0},
  {32'hBF800001, 32'h3F800001, 3'd3, 32'hBF800002, 1'b0, 1'b0},
  {32'h3F800800, 32'h3F800800, 3'd0, 32'h3F801000, 1'b0, 1'b0}, // exact tie
  {32'h3F800800, 32'h3F800800, 3'd1, 32'h3F801000, 1'b0, 1'b0},
  {32'h3F800800, 32'h3F800800, 3'd4, 32'h3F801001, 1'b0, 1'b0},
  {32'h3F800800, 32'h3F800800, 3'd7, 32'h3F801001, 1'b0, 1'b0}, // 7 acts as rmm
  {32'h7F800000, 32'h40000000, 3'd0, 32'h7F800000, 1'b1, 1'b0}, // biased exp 256
  {32'h7F800000, 32'h00000000, 3'd0, 32'h7FC00000, 1'b0, 1'b0},
  {32'h7FC00001, 32'h3F800000, 3'd0, 32'h7FC00000, 1'b1, 1'b0}, // biased exp 255
  {32'h80000000, 32'h40A00000, 3'd0, 32'h80000000, 1'b0, 1'b0},
  {32'h7F000000, 32'h40000000, 3'd0, 32'h7F800000, 1'b1, 1'b0},
  {32'h00800000, 32'h3F000000, 3'd0, 32'h00000000, 1'b0, 1'b1},
  {32'h3F800000, 32'h3F800000, 3'd0, 32'h3F800000, 1'b0, 1'b0},
  {32'h40000000, 32'h40400000, 3'd0, 32'h40C00000, 1'b0, 1'b0},
  {32'h40400000, 32'h40400000, 3'd0, 32'h41100000, 1'b0, 1'b0},
  {32'hC0000000, 32'h40800000, 3'd0, 32'hC1000000, 1'b0, 1'b0},
  {32'h3F000000, 32'h3E800000, 3'd0, 32'h3E000000, 1'b0, 1'b0},
  {32'h41200000, 32'h41200000, 3'd0, 32'h42C80000, 1'b0, 1'b0}
};

`endif

/* testbench/tb_fpm.sv */
`timescale 1ns/1ps

module tb_fpm;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_wdata;
  logic [31:0] wb_rdata;
  logic        wb_ack;
  int          cycles = 0;

  `include "tb_fpm_vectors.svh"

  localparam int MAX_CYCLES = 40 * N_VEC + 20;

  fpm_wb_top #(.JOB_DEPTH(4), .RES_DEPTH(4)) UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // ack sampled mid-cycle, away from the edge
  task automatic wait_ack();
    do @(negedge clk); while (!wb_ack);
  endtask

  task automatic end_cycle();
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic bus_write(input logic [1:0] adr, input logic [31:0] data);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_wdata <= data;
    wait_ack();
    end_cycle();
  endtask

  task automatic bus_read(input logic [1:0] adr, output logic [31:0] data);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    wait_ack();
    data = wb_rdata;
    end_cycle();
  endtask

  task automatic push_job(input int i);
    bus_write(fpm_pkg::ADR_X, VECS[i][100:69]);
    bus_write(fpm_pkg::ADR_Y, VECS[i][68:37]); // stalls while job fifo is full
  endtask

  task automatic pop_and_check(input int i);
    logic [31:0] rd;
    bus_read(fpm_pkg::ADR_Y, rd);
    check(rd, VECS[i][33:2], $sformatf("vector %0d product", i));
    bus_read(fpm_pkg::ADR_FLAGS, rd);
    check(rd, {30'd0, VECS[i][0], VECS[i][1]}, $sformatf("vector %0d flags", i));
  endtask

  initial begin
    logic [31:0] rd;
    rst_n    <= 1'b0;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= 2'd0;
    wb_wdata <= 32'd0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < N_SINGLE; i++) begin
      bus_write(fpm_pkg::ADR_RMODE, {29'd0, VECS[i][36:34]});
      bus_read(fpm_pkg::ADR_RMODE, rd);
      check(rd, {29'd0, VECS[i][36:34]}, $sformatf("vector %0d mode readback", i));
      push_job(i);
      pop_and_check(i);
    end

    // all queued jobs first, results come back in order
    bus_write(fpm_pkg::ADR_RMODE, {29'd0, VECS[N_SINGLE][36:34]});
    for (int i = N_SINGLE; i < N_VEC; i++)
      push_job(i);
    for (int i = N_SINGLE; i < N_VEC; i++)
      pop_and_check(i);

    bus_read(fpm_pkg::ADR_X, rd);
    check(rd, VECS[N_VEC-1][100:69], "x readback");

    repeat (2) @(posedge clk); // let the last ack settle in the checker

    if (UUT.u_wb_chk.fail_cnt != 0) begin
      $display("%0d bus protocol assertions failed", UUT.u_wb_chk.fail_cnt);
      $display("TEST FAILED");
      $fatal(1, "assertion failure");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

/* testbench/fpm_wb_chk.sv */
`timescale 1ns/1ps

module fpm_wb_chk (
  input logic clk,
  input logic rst_n,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack
);

  int unsigned fail_cnt = 0;

  ack_in_reset: assert property (@(posedge clk) !rst_n |-> !wb_ack)
    else begin
      $error("wb_ack high while reset is active");
      fail_cnt++;
    end

  // ack only answers a live request
  ack_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n) wb_ack |-> (wb_cyc && wb_stb))
    else begin
      $error("wb_ack high without cyc and stb");
      fail_cnt++;
    end

  ack_one_cycle: assert property (
    @(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
    else begin
      $error("wb_ack high for two cycles in a row");
      fail_cnt++;
    end

endmodule

bind fpm_wb_top fpm_wb_chk u_wb_chk (
  .clk    (clk),
  .rst_n  (rst_n),
  .wb_cyc (wb_cyc),
  .wb_stb (wb_stb),
  .wb_ack (wb_ack)
);

/* verilog/fpm_wb_top.sv */
`timescale 1ns/1ps

module fpm_wb_top #(
  parameter int JOB_DEPTH = 4,
  parameter int RES_DEPTH = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [1:0]  wb_adr,
  input  logic [31:0] wb_wdata,
  output logic [31:0] wb_rdata,
  output logic        wb_ack
);

  logic                      job_push;
  logic [fpm_pkg::JOB_W-1:0] job_wdata;
  logic                      job_full;
  logic                      job_pop;
  logic [fpm_pkg::JOB_W-1:0] job_rdata;
  logic                      job_empty;
  logic                      res_push;
  logic [fpm_pkg::RES_W-1:0] res_wdata;
  logic                      res_full;
  logic                      res_pop;
  logic [fpm_pkg::RES_W-1:0] res_rdata;
  logic                      res_empty;

  wb_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_wdata  (wb_wdata),
    .wb_rdata  (wb_rdata),
    .wb_ack    (wb_ack),
    .job_push  (job_push),
    .job_data  (job_wdata),
    .job_full  (job_full),
    .res_pop   (res_pop),
    .res_data  (res_rdata),
    .res_empty (res_empty)
  );

  sync_fifo #(.WIDTH(fpm_pkg::JOB_W), .DEPTH(JOB_DEPTH)) u_job_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (job_push),
    .push_data (job_wdata),
    .full      (job_full),
    .pop       (job_pop),
    .pop_data  (job_rdata),
    .empty     (job_empty)
  );

  fp_mul_pipe u_pipe (
    .clk       (clk),
    .rst_n     (rst_n),
    .job_pop   (job_pop),
    .job_data  (job_rdata),
    .job_empty (job_empty),
    .res_push  (res_push),
    .res_data  (res_wdata),
    .res_full  (res_full)
  );

  sync_fifo #(.WIDTH(fpm_pkg::RES_W), .DEPTH(RES_DEPTH)) u_res_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (res_push),
    .push_data (res_wdata),
    .full      (res_full),
    .pop       (res_pop),
    .pop_data  (res_rdata),
    .empty     (res_empty)
  );

endmodule

/* verilog/fp_mul_pipe.sv */
`timescale 1ns/1ps

module fp_mul_pipe (
  input  logic                      clk,
  input  logic                      rst_n,
  output logic                      job_pop,
  input  logic [fpm_pkg::JOB_W-1:0] job_data,
  input  logic                      job_empty,
  output logic                      res_push,
  output logic [fpm_pkg::RES_W-1:0] res_data,
  input  logic                      res_full
);

  fpm_pkg::fp_word_t x;
  fpm_pkg::fp_word_t y;
  logic [2:0]        job_rm;
  logic              x_max, y_max, x_zer, y_zer;
  logic              x_inf, y_inf, x_nan, y_nan;
  logic [27:0]       pp [9];
  logic              hold;
  logic              s1_vld, s2_vld, s3_vld;

  logic              s1_sign;
  logic [7:0]        s1_exp_x, s1_exp_y;
  logic [2:0]        s1_rm;
  logic              s1_nan, s1_inf, s1_zer;
  logic [27:0]       s1_pp [9];

  logic [47:0]       prod;
  logic [47:0]       prod_sh;
  logic              s2_sign;
  logic [7:0]        s2_exp_x, s2_exp_y;
  logic [2:0]        s2_rm;
  logic              s2_nan, s2_inf, s2_zer;
  logic [26:0]       s2_sig;
  logic              s2_norm_n;

  fpm_pkg::fp_word_t rp_result;
  logic              rp_ovrf, rp_udrf;
  logic [fpm_pkg::RES_W-1:0] s3_res;

  assign x.raw  = job_data[31:0];
  assign y.raw  = job_data[63:32];
  assign job_rm = job_data[66:64];

  assign x_max = &x.f.exp;
  assign y_max = &y.f.exp;
  assign x_zer = ~|x.f.exp; // subnormal counts as zero
  assign y_zer = ~|y.f.exp;
  assign x_inf = x_max & ~|x.f.frac;
  assign y_inf = y_max & ~|y.f.frac;
  assign x_nan = x_max & |x.f.frac;
  assign y_nan = y_max & |y.f.frac;

  assign hold     = s3_vld & res_full; // whole pipe stalls
  assign job_pop  = ~job_empty & ~hold;
  assign res_push = s3_vld & ~res_full;
  assign res_data = s3_res;

  booth_pp_gen u_booth (
    .frac_x (x.f.frac),
    .frac_y (y.f.frac),
    .pp     (pp)
  );

  // partial products summed in one go
  always_comb begin
    prod = '0;
    for (int i = 0; i < 9; i++)
      prod = prod + ({{20{s1_pp[i][27]}}, s1_pp[i]} << (3 * i));
  end

  assign prod_sh = prod << !prod[47];

  fp_round_pack u_round (
    .sign   (s2_sign),
    .exp_x  (s2_exp_x),
    .exp_y  (s2_exp_y),
    .r_mode (s2_rm),
    .sig    (s2_sig),
    .norm_n (s2_norm_n),
    .nan_in (s2_nan),
    .inf_in (s2_inf),
    .zer_in (s2_zer),
    .result (rp_result),
    .ovrf   (rp_ovrf),
    .udrf   (rp_udrf)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld <= 1'b0;
      s2_vld <= 1'b0;
      s3_vld <= 1'b0;
    end else if (!hold) begin
      s1_vld <= job_pop;
      s2_vld <= s1_vld;
      s3_vld <= s2_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      s1_sign   <= x.f.sign ^ y.f.sign;
      s1_exp_x  <= x.f.exp;
      s1_exp_y  <= y.f.exp;
      s1_rm     <= job_rm;
      s1_nan    <= x_nan | y_nan | (x_inf & y_zer) | (y_inf & x_zer);
      s1_inf    <= x_inf | y_inf;
      s1_zer    <= x_zer | y_zer;
      s1_pp     <= pp;
      s2_sign   <= s1_sign;
      s2_exp_x  <= s1_exp_x;
      s2_exp_y  <= s1_exp_y;
      s2_rm     <= s1_rm;
      s2_nan    <= s1_nan;
      s2_inf    <= s1_inf;
      s2_zer    <= s1_zer;
      s2_sig    <= {prod_sh[47:22], |prod_sh[21:0]}; // 26 bits plus sticky
      s2_norm_n <= prod[47];                         // product was 2 or more
      s3_res    <= {rp_udrf, rp_ovrf, rp_result.raw};
    end
  end

endmodule

/* verilog/fp_round_pack.sv */
`timescale 1ns/1ps

module fp_round_pack (
  input  logic                      sign,
  input  logic [fpm_pkg::EXP_W-1:0] exp_x,
  input  logic [fpm_pkg::EXP_W-1:0] exp_y,
  input  logic [2:0]                r_mode,
  input  logic [26:0]               sig,
  input  logic                      norm_n,
  input  logic                      nan_in,
  input  logic                      inf_in,
  input  logic                      zer_in,
  output fpm_pkg::fp_word_t         result,
  output logic                      ovrf,
  output logic                      udrf
);

  logic [2:0]                  rm;
  logic                        lsb;
  logic                        guard;
  logic                        rs; // round or sticky
  logic                        inexact;
  logic                        inc;
  logic [24:0]                 sig_rnd;
  logic                        norm_r;
  logic [fpm_pkg::FRAC_W-1:0]  frac;
  logic [9:0]                  exp_sum;
  logic [9:0]                  exp_z;

  assign rm      = (r_mode > fpm_pkg::RM_RMM) ? fpm_pkg::RM_RMM : r_mode; // 5..7 as rmm
  assign lsb     = sig[3];
  assign guard   = sig[2];
  assign rs      = sig[1] | sig[0];
  assign inexact = guard | rs;

  always_comb begin
    case (rm)
      fpm_pkg::RM_RNE: inc = guard & (rs | lsb);
      fpm_pkg::RM_RTZ: inc = 1'b0;
      fpm_pkg::RM_RDN: inc = sign & inexact; // magnitude grows when negative
      fpm_pkg::RM_RUP: inc = ~sign & inexact;
      default:         inc = guard;
    endcase
  end

  assign sig_rnd = {1'b0, sig[26:3]} + 25'(inc);
  assign norm_r  = sig_rnd[24]; // rounding carried out
  assign frac    = norm_r ? sig_rnd[23:1] : sig_rnd[22:0];

  // biased sum before removing one bias
  assign exp_sum = {2'b00, exp_x} + {2'b00, exp_y} + {9'd0, norm_n | norm_r};
  assign exp_z   = exp_sum - 10'(fpm_pkg::EXP_BIAS);

  assign ovrf = (exp_sum >= 10'(255 + fpm_pkg::EXP_BIAS));
  assign udrf = (exp_sum <= 10'(fpm_pkg::EXP_BIAS));

  always_comb begin
    result.f.sign = sign;
    result.f.exp  = exp_z[fpm_pkg::EXP_W-1:0];
    result.f.frac = frac;
    if (nan_in) begin
      result.raw = fpm_pkg::QNAN;
    end else if (inf_in || ovrf) begin
      result.f.exp  = '1;
      result.f.frac = '0;
    end else if (zer_in || udrf) begin
      result.f.exp  = '0; // subnormals flushed too
      result.f.frac = '0;
    end
  end

endmodule

/* verilog/booth_pp_gen.sv */
`timescale 1ns/1ps

module booth_pp_gen (
  input  logic [fpm_pkg::FRAC_W-1:0] frac_x,
  input  logic [fpm_pkg::FRAC_W-1:0] frac_y,
  output logic [27:0]                pp [9]
);

  logic [27:0] y1;
  logic [27:0] y2;
  logic [27:0] y3;
  logic [27:0] y4;
  logic [27:0] xs;

  // radix-8 digit select, grp is {x[3i+2], x[3i+1], x[3i], x[3i-1]}
  function automatic logic [27:0] booth_sel(
    input logic [3:0]  grp,
    input logic [27:0] m1,
    input logic [27:0] m2,
    input logic [27:0] m3,
    input logic [27:0] m4
  );
    logic [27:0] mag;
    case (grp)
      4'b0001, 4'b0010, 4'b1101, 4'b1110: mag = m1;
      4'b0011, 4'b0100, 4'b1011, 4'b1100: mag = m2;
      4'b0101, 4'b0110, 4'b1001, 4'b1010: mag = m3;
      4'b0111, 4'b1000:                   mag = m4;
      default:                            mag = '0;
    endcase
    return grp[3] ? -mag : mag; // top bit carries the -4 weight
  endfunction

  // multiplicand with hidden one
  assign y1 = {4'b0000, 1'b1, frac_y};
  assign y2 = y1 << 1;
  assign y4 = y1 << 2;
  assign y3 = y1 + y2; // the one hard multiple

  // zero pad on top so the last digit stays non-negative
  assign xs = {3'b000, 1'b1, frac_x, 1'b0};

  always_comb begin
    for (int i = 0; i < 9; i++)
      pp[i] = booth_sel(xs[3*i +: 4], y1, y2, y3, y4); // weight 8**i
  end

endmodule

/* verilog/wb_regs.sv */
`timescale 1ns/1ps

module wb_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [1:0]                wb_adr,
  input  logic [31:0]               wb_wdata,
  output logic [31:0]               wb_rdata,
  output logic                      wb_ack,
  output logic                      job_push,
  output logic [fpm_pkg::JOB_W-1:0] job_data,
  input  logic                      job_full,
  output logic                      res_pop,
  input  logic [fpm_pkg::RES_W-1:0] res_data,
  input  logic                      res_empty
);

  fpm_pkg::fp_word_t x_reg;
  logic [2:0]        r_mode;
  logic [1:0]        flags; // {udrf, ovrf} of the last result read
  logic              req;
  logic              y_wr;
  logic              y_rd;
  logic              go;

  assign req  = wb_cyc & wb_stb & ~wb_ack; // stb still high during ack cycle
  assign y_wr = wb_we & (wb_adr == fpm_pkg::ADR_Y);
  assign y_rd = ~wb_we & (wb_adr == fpm_pkg::ADR_Y);

  // wait states on full job fifo or empty result fifo
  assign go = req & ~(y_wr & job_full) & ~(y_rd & res_empty);

  assign job_push = go & y_wr;
  assign res_pop  = go & y_rd;
  assign job_data = {r_mode, wb_wdata, x_reg.raw};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
      r_mode <= fpm_pkg::RM_RNE;
      flags  <= 2'b00;
    end else begin
      wb_ack <= go;
      if (go && wb_we && wb_adr == fpm_pkg::ADR_RMODE)
        r_mode <= wb_wdata[2:0];
      if (res_pop)
        flags <= res_data[fpm_pkg::RES_W-1 -: 2];
    end
  end

  always_ff @(posedge clk) begin
    if (go && wb_we && wb_adr == fpm_pkg::ADR_X)
      x_reg.raw <= wb_wdata;
  end

  // read data lines up with ack
  always_ff @(posedge clk) begin
    if (go && !wb_we) begin
      case (wb_adr)
        fpm_pkg::ADR_X:     wb_rdata <= x_reg.raw;
        fpm_pkg::ADR_RMODE: wb_rdata <= {29'd0, r_mode};
        fpm_pkg::ADR_Y:     wb_rdata <= res_data[31:0];
        default:            wb_rdata <= {30'd0, flags};
      endcase
    end
  end

endmodule

/* verilog/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 4 // power of two, 2 or more
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  output logic             full,
  input  logic             pop,
  output logic [WIDTH-1:0] pop_data,
  output logic             empty
);

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [AW:0]      count;
  logic             do_push;
  logic             do_pop;

  assign full     = (count == (AW+1)'(DEPTH));
  assign empty    = (count == '0);
  assign do_push  = push & ~full;
  assign do_pop   = pop & ~empty;
  assign pop_data = mem[rd_ptr]; // head entry

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1; // wraps, depth is 2**AW
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push != do_pop)
        count <= do_push ? count + 1'b1 : count - 1'b1;
    end
  end

endmodule

/* verilog/fpm_pkg.sv */
package fpm_pkg;

  localparam int EXP_W    = 8;
  localparam int FRAC_W   = 23;
  localparam int EXP_BIAS = 127;

  localparam logic [31:0] QNAN = 32'h7fc0_0000; // canonical quiet nan

  // rounding mode codes
  localparam logic [2:0] RM_RNE = 3'd0; // nearest, ties to even
  localparam logic [2:0] RM_RTZ = 3'd1;
  localparam logic [2:0] RM_RDN = 3'd2; // toward -inf
  localparam logic [2:0] RM_RUP = 3'd3; // toward +inf
  localparam logic [2:0] RM_RMM = 3'd4; // nearest, ties away

  // word addresses
  localparam logic [1:0] ADR_X     = 2'd0;
  localparam logic [1:0] ADR_RMODE = 2'd1;
  localparam logic [1:0] ADR_Y     = 2'd2;
  localparam logic [1:0] ADR_FLAGS = 2'd3;

  // job is {r_mode, y, x}
  localparam int JOB_W = 67;
  // result is {udrf, ovrf, z}
  localparam int RES_W = 34;

  // binary32 word, raw or split into fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic              sign;
      logic [EXP_W-1:0]  exp;
      logic [FRAC_W-1:0] frac;
    } f;
  } fp_word_t;

endpackage
